//--- src/sys_settings.svh
`ifndef SYS_SETTINGS_SVH
`define SYS_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Audio path
//////////////////////////////////////////////////////////////////////

// Width of one audio sample
`define SAMPLE_W 16

// Mixer channels, 0 is left and 1 is right
`define AUD_CHANNELS 2

// Attenuation, mute on top of a 4-bit shift
`define ATT_W 5

//////////////////////////////////////////////////////////////////////
// Video sync
//////////////////////////////////////////////////////////////////////

// Phase length counter, saturating
`define SYNC_CNT_W 16

//////////////////////////////////////////////////////////////////////
// Host command codes
//////////////////////////////////////////////////////////////////////

// LED override mask and state
`define CMD_LED 8'h25

// Volume attenuation
`define CMD_VOLUME 8'h26

`endif

//--- src/sys_pkg.sv
`default_nettype none

`include "sys_settings.svh"

package sys_pkg;

	// One 16-bit word from the host port, seen through its command
	typedef union packed {
		logic [15:0] raw;

		// First word of a frame
		struct packed {
			logic [7:0] unused;
			logic [7:0] code;
		} cmd;

		// Data of CMD_LED
		struct packed {
			logic [7:0] mask;
			logic [7:0] state;
		} leds;

		// Data of CMD_VOLUME
		struct packed {
			logic [10:0] unused;
			logic        mute;
			logic [3:0]  shift;
		} volume;
	} host_word_u;

	// Signed audio sample
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// Cross-feed strength between left and right
	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,
		MIX_MEDIUM = 2'd2,
		MIX_MONO   = 2'd3
	} mix_mode_t;

endpackage

`default_nettype wire

//--- src/hps_cmd_regs.sv
`default_nettype none

`include "sys_settings.svh"

module hps_cmd_regs
	import sys_pkg::*;
(
	input  wire              clk_sys,
	input  wire              resetd,

	input  wire              i_io_clk,
	input  wire              i_io_uio,
	input  wire host_word_u  i_io_din,

	input  wire [1:0]        i_led_power,
	input  wire              i_led_disk,
	input  wire              i_led_user,

	output logic             o_io_ack,
	output logic [`ATT_W-1:0] o_att,
	output logic [7:0]       o_led
);

	logic [1:0] clk_sync;
	logic [1:0] uio_sync;
	logic       io_strobe;
	host_word_u din_r;

	logic       has_cmd;
	logic [7:0] cmd;

	logic [7:0] led_mask;
	logic [7:0] led_state;
	logic [7:0] led_status;
	logic       lamp_power;

	//////////////////////////////////////////////////////////////////////
	// Host port synchronizer
	//////////////////////////////////////////////////////////////////////

	// Two flops per level, ack is the third stage of the host clock
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
			o_io_ack <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], i_io_clk};
			uio_sync <= {uio_sync[0], i_io_uio};
			o_io_ack <= clk_sync[1];
		end
	end

	// Rising edge of the synchronized host clock
	assign io_strobe = clk_sync[1] & ~o_io_ack;

	// Host holds the word well before the edge, one stage is enough
	always_ff @(posedge clk_sys) begin
		din_r <= i_io_din;
	end

	//////////////////////////////////////////////////////////////////////
	// Command framing and registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			led_mask  <= '0;
			led_state <= '0;
			o_att     <= '0;
		end else if (!uio_sync[1]) begin
			// Frame closed, next write is a command again
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
			end else begin
				case (cmd)
					`CMD_LED: begin
						led_mask  <= din_r.leds.mask;
						led_state <= din_r.leds.state;
					end
					`CMD_VOLUME: begin
						o_att <= {din_r.volume.mute, din_r.volume.shift};
					end
					default: begin
						// Unknown command, data dropped
					end
				endcase
			end
		end
	end

	// Command code of the open frame
	always_ff @(posedge clk_sys) begin
		if (io_strobe && uio_sync[1] && !has_cmd) begin
			cmd <= din_r.cmd.code;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// LED bank
	//////////////////////////////////////////////////////////////////////

	// Power lamp steady on unless the core takes it over
	assign lamp_power = i_led_power[1] ? i_led_power[0] : 1'b1;

	// Bit 6 was the PLL lock lamp, now tied low
	assign led_status = {3'b000, lamp_power, 1'b0, i_led_disk, 1'b0, i_led_user};

	assign o_led = (led_mask & led_state) | (~led_mask & led_status);

endmodule

`default_nettype wire

//--- src/audio_mix.sv
`default_nettype none

`include "sys_settings.svh"

module audio_mix
	import sys_pkg::*;
(
	input  wire                clk_sys,
	input  wire                resetd,

	input  wire sample_t       i_core,
	input  wire                i_signed,
	input  wire mix_mode_t     i_mode,
	input  wire [`ATT_W-1:0]   i_att,
	input  wire sample_t       i_pre_other,

	output sample_t            o_pre,
	output sample_t            o_out
);

	sample_t            d1;
	sample_t            d2;
	sample_t            d3;
	sample_t            ca;

	logic signed [16:0] a1;
	logic signed [16:0] a3;
	logic signed [16:0] a4;

	//////////////////////////////////////////////////////////////////////
	// Glitch filter
	//////////////////////////////////////////////////////////////////////

	// Take a sample only after three equal cycles
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d1 == d2 && d2 == d3) begin
				ca <= d3;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Cross-feed, attenuation and clamp
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			a1    <= '0;
			o_pre <= '0;
			a3    <= '0;
			a4    <= '0;
			o_out <= '0;
		end else begin
			// Unsigned input lands at half scale
			a1 <= i_signed ? {ca[15], ca} : {2'b00, ca[15:1]};

			o_pre <= a1[16:1];

			case (i_mode)
				MIX_NONE:   a3 <= a1;
				MIX_LIGHT:  a3 <= a1 - (a1 >>> 3) + (i_pre_other >>> 2);
				MIX_MEDIUM: a3 <= a1 - (a1 >>> 2) + (i_pre_other >>> 1);
				MIX_MONO:   a3 <= (a1 >>> 1) + i_pre_other;
				default:    a3 <= a1;
			endcase

			if (i_att[`ATT_W-1]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[`ATT_W-2:0];
			end

			// Saturate when the top two bits disagree
			if (a4[16] != a4[15]) begin
				o_out <= {a4[16], {15{~a4[16]}}};
			end else begin
				o_out <= a4[15:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/audio_dac.sv
`default_nettype none

`include "sys_settings.svh"

module audio_dac
	import sys_pkg::*;
(
	input  wire                              clk_sys,
	input  wire                              resetd,

	input  wire sample_t [`AUD_CHANNELS-1:0] i_samples,

	output logic [`AUD_CHANNELS-1:0]         o_dac
);

	for (genvar ch = 0; ch < `AUD_CHANNELS; ch++) begin : g_ch
		logic [`SAMPLE_W-1:0] acc;
		logic [`SAMPLE_W-1:0] level;

		// Offset binary, zero sample sits at mid density
		assign level = {~i_samples[ch][`SAMPLE_W-1], i_samples[ch][`SAMPLE_W-2:0]};

		// First order loop, carry out is the bit
		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				acc       <= '0;
				o_dac[ch] <= 1'b0;
			end else begin
				{o_dac[ch], acc} <= {1'b0, acc} + {1'b0, level};
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sync_polarity.sv
`default_nettype none

`include "sys_settings.svh"

module sync_polarity (
	input  wire  clk_sys,
	input  wire  resetd,

	input  wire  i_sync,
	output logic o_sync
);

	logic                   s1;
	logic                   s2;
	logic [`SYNC_CNT_W-1:0] cnt;
	logic [`SYNC_CNT_W-1:0] len_hi;
	logic [`SYNC_CNT_W-1:0] len_lo;
	logic                   pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Rising edge ends a low phase, falling edge a high one
			if (!s2 && s1) begin
				len_lo <= cnt;
			end
			if (s2 && !s1) begin
				len_hi <= cnt;
			end

			if (s1 != s2) begin
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end

			// Long high phase means the sync is active low
			pol <= len_hi > len_lo;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

`default_nettype wire

//--- src/sys_top.sv
`default_nettype none

`include "sys_settings.svh"

module sys_top
	import sys_pkg::*;
(
	input  wire          clk_sys,
	input  wire          resetd,

	// Host command port
	input  wire          i_io_clk,
	input  wire          i_io_uio,
	input  wire [15:0]   i_io_din,
	output logic         o_io_ack,

	// Core audio
	input  wire sample_t i_audio_l,
	input  wire sample_t i_audio_r,
	input  wire          i_audio_signed,
	input  wire [1:0]    i_audio_mix,

	// Core video sync
	input  wire          i_hs,
	input  wire          i_vs,

	// Core status lamps
	input  wire [1:0]    i_led_power,
	input  wire          i_led_disk,
	input  wire          i_led_user,

	output logic [7:0]   o_led,
	output sample_t      o_audio_l,
	output sample_t      o_audio_r,
	output logic         o_dac_l,
	output logic         o_dac_r,
	output logic         o_hs,
	output logic         o_vs
);

	logic [`ATT_W-1:0]                att;
	mix_mode_t                        mix_mode;
	sample_t [`AUD_CHANNELS-1:0]      core_smp;
	sample_t [`AUD_CHANNELS-1:0]      pre_smp;
	sample_t [`AUD_CHANNELS-1:0]      mix_out;
	logic    [`AUD_CHANNELS-1:0]      dac_bits;

	//////////////////////////////////////////////////////////////////////
	// Host port and registers
	//////////////////////////////////////////////////////////////////////

	hps_cmd_regs u_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_clk    (i_io_clk),
		.i_io_uio    (i_io_uio),
		.i_io_din    (i_io_din),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.i_led_user  (i_led_user),
		.o_io_ack    (o_io_ack),
		.o_att       (att),
		.o_led       (o_led)
	);

	//////////////////////////////////////////////////////////////////////
	// Audio
	//////////////////////////////////////////////////////////////////////

	assign mix_mode = mix_mode_t'(i_audio_mix);
	assign core_smp = {i_audio_r, i_audio_l};

	// Each channel takes its cross-feed from the other one
	for (genvar ch = 0; ch < `AUD_CHANNELS; ch++) begin : g_mix
		audio_mix u_mix (
			.clk_sys     (clk_sys),
			.resetd      (resetd),
			.i_core      (core_smp[ch]),
			.i_signed    (i_audio_signed),
			.i_mode      (mix_mode),
			.i_att       (att),
			.i_pre_other (pre_smp[ch ^ 1]),
			.o_pre       (pre_smp[ch]),
			.o_out       (mix_out[ch])
		);
	end

	audio_dac u_dac (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_samples (mix_out),
		.o_dac     (dac_bits)
	);

	assign o_audio_l = mix_out[0];
	assign o_audio_r = mix_out[1];
	assign o_dac_l   = dac_bits[0];
	assign o_dac_r   = dac_bits[1];

	//////////////////////////////////////////////////////////////////////
	// Sync polarity
	//////////////////////////////////////////////////////////////////////

	sync_polarity u_sync_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity u_sync_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

endmodule

`default_nettype wire

//--- tests/tb_sys_top.sv
`default_nettype none

`include "sys_settings.svh"

module tb_sys_top;

	timeunit 1ns;
	timeprecision 100ps;

	// Upper bound on the summed length of all tests in cycles
	localparam int TEST_CYCLES = 100_000;

	logic               clk_sys;
	logic               resetd;
	logic               i_io_clk;
	logic               i_io_uio;
	logic [15:0]        i_io_din;
	logic signed [15:0] i_audio_l;
	logic signed [15:0] i_audio_r;
	logic               i_audio_signed;
	logic [1:0]         i_audio_mix;
	logic               i_hs;
	logic               i_vs;
	logic [1:0]         i_led_power;
	logic               i_led_disk;
	logic               i_led_user;

	logic               o_io_ack;
	logic [7:0]         o_led;
	logic signed [15:0] o_audio_l;
	logic signed [15:0] o_audio_r;
	logic               o_dac_l;
	logic               o_dac_r;
	logic               o_hs;
	logic               o_vs;

	string      cur_test;
	int         errors;
	int         test_errors0;
	int         tests_run;
	int         tests_failed;
	logic       ack_en;
	logic [2:0] io_hist;
	logic [4:0] cur_att;

	sys_top uut (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_clk       (i_io_clk),
		.i_io_uio       (i_io_uio),
		.i_io_din       (i_io_din),
		.o_io_ack       (o_io_ack),
		.i_audio_l      (i_audio_l),
		.i_audio_r      (i_audio_r),
		.i_audio_signed (i_audio_signed),
		.i_audio_mix    (i_audio_mix),
		.i_hs           (i_hs),
		.i_vs           (i_vs),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_led_user     (i_led_user),
		.o_led          (o_led),
		.o_audio_l      (o_audio_l),
		.o_audio_r      (o_audio_r),
		.o_dac_l        (o_dac_l),
		.o_dac_r        (o_dac_r),
		.o_hs           (o_hs),
		.o_vs           (o_vs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Checking and reporting
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string what, input int exp, input int act, input int tol);
		assert ((act - exp) <= tol && (exp - act) <= tol) else begin
			$display("Error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors0 = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors0) begin
			$display("Test %s ok", cur_test);
		end else begin
			tests_failed++;
			$display("Test %s FAIL with %0d errors", cur_test, errors - test_errors0);
		end
	endtask

	// Ack is the host clock three cycles late
	always @(posedge clk_sys) begin
		if (ack_en) begin
			check_val("io_ack", io_hist[2], o_io_ack, 0);
		end
		io_hist <= {io_hist[1:0], i_io_clk};
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] led_status(input logic [1:0] pwr, input logic disk,
		input logic user);
		logic [7:0] lamps;
		lamps = 8'h00;
		// User lamp on bit 0 and disk lamp on bit 2
		lamps[0] = user;
		lamps[2] = disk;
		// Power lamp follows the low bit only when the high bit is set
		lamps[4] = ~pwr[1] | pwr[0];
		return lamps;
	endfunction

	function automatic int base_val(input logic [15:0] s, input logic sgn);
		return sgn ? int'($signed(s)) : int'(s >> 1);
	endfunction

	function automatic int mix_model(input logic [15:0] own, input logic [15:0] other,
		input logic sgn, input logic [1:0] mode, input logic [4:0] att);
		int a;
		int p;
		int m;
		a = base_val(own, sgn);
		p = base_val(other, sgn) >>> 1;
		case (mode)
			2'd0: m = a;
			2'd1: m = a - (a >>> 3) + (p >>> 2);
			2'd2: m = a - (a >>> 2) + (p >>> 1);
			default: m = (a >>> 1) + p;
		endcase
		m = att[4] ? 0 : (m >>> att[3:0]);
		if (m > 32767) m = 32767;
		if (m < -32768) m = -32768;
		return m;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic host_write(input logic [15:0] word);
		@(negedge clk_sys);
		i_io_din = word;
		repeat (2) @(negedge clk_sys);
		i_io_clk = 1'b1;
		repeat (6) @(negedge clk_sys);
		i_io_clk = 1'b0;
		repeat (6) @(negedge clk_sys);
	endtask

	task automatic host_frame(input logic [7:0] code, input logic [15:0] data);
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		repeat (4) @(negedge clk_sys);
		host_write({8'h00, code});
		host_write(data);
		i_io_uio = 1'b0;
		repeat (6) @(negedge clk_sys);
	endtask

	// Returns on the posedge where the mixer has settled
	task automatic set_audio(input logic [15:0] l, input logic [15:0] r, input logic sgn,
		input logic [1:0] mode);
		@(negedge clk_sys);
		i_audio_l = l;
		i_audio_r = r;
		i_audio_signed = sgn;
		i_audio_mix = mode;
		repeat (16) @(posedge clk_sys);
	endtask

	task automatic check_mix();
		check_val("audio_l", mix_model(i_audio_l, i_audio_r, i_audio_signed, i_audio_mix,
			cur_att), o_audio_l, 0);
		check_val("audio_r", mix_model(i_audio_r, i_audio_l, i_audio_signed, i_audio_mix,
			cur_att), o_audio_r, 0);
	endtask

	// Short pulses of 4 in 40 cycles on hs and 6 in 64 on vs
	// Phase runs on from first so calls join without a break
	task automatic run_sync(input logic inv, input int first, input int cycles,
		input logic check);
		int t;
		for (t = first; t < first + cycles; t++) begin
			@(negedge clk_sys);
			i_hs = ((t % 40) < 4) ^ inv;
			i_vs = ((t % 64) < 6) ^ inv;
			@(posedge clk_sys);
			if (check) begin
				check_val("hs", i_hs ^ inv, o_hs, 0);
				check_val("vs", i_vs ^ inv, o_vs, 0);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		repeat (2 * TEST_CYCLES) @(posedge clk_sys);
		$display("Timeout in test %s, run did not end within %0d cycles", cur_test,
			2 * TEST_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [15:0] led_word;
		logic [7:0]  exp_led;
		int          exp_l;
		int          exp_r;
		int          ones_l;
		int          ones_r;

		void'($urandom(32'hd65f_0131));
		cur_test = "reset";
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		ack_en = 1'b0;
		io_hist = '0;
		cur_att = '0;
		resetd = 1'b1;
		i_io_clk = 1'b0;
		i_io_uio = 1'b0;
		i_io_din = '0;
		// Nonzero samples while reset is held
		i_audio_l = 16'h1234;
		i_audio_r = 16'hc3a5;
		i_audio_signed = 1'b1;
		i_audio_mix = 2'd0;
		i_hs = 1'b0;
		i_vs = 1'b0;
		i_led_power = 2'b00;
		i_led_disk = 1'b0;
		i_led_user = 1'b0;
		repeat (16) @(negedge clk_sys);
		resetd = 1'b0;

		start_test("reset_ack");
		@(negedge clk_sys);
		i_led_power = 2'($urandom);
		i_led_disk = 1'($urandom);
		i_led_user = 1'($urandom);
		@(posedge clk_sys);
		check_val("led", led_status(i_led_power, i_led_disk, i_led_user), o_led, 0);
		check_val("audio_l", 0, o_audio_l, 0);
		check_val("audio_r", 0, o_audio_r, 0);
		check_val("io_ack", 0, o_io_ack, 0);
		ack_en = 1'b1;
		repeat (3) host_write(16'($urandom));
		end_test();

		start_test("led_framing");
		led_word = 16'($urandom);
		host_frame(`CMD_LED, led_word);
		exp_led = (led_word[15:8] & led_word[7:0]) |
			(~led_word[15:8] & led_status(i_led_power, i_led_disk, i_led_user));
		@(posedge clk_sys);
		check_val("led", exp_led, o_led, 0);
		host_write(~led_word);
		@(posedge clk_sys);
		check_val("led after closed frame", exp_led, o_led, 0);
		host_frame(8'h42, ~led_word);
		@(posedge clk_sys);
		check_val("led after unknown command", exp_led, o_led, 0);
		end_test();

		start_test("mixer_modes");
		for (int i = 0; i < 8; i++) begin
			set_audio(16'($urandom), 16'($urandom), i < 4, 2'(i));
			check_mix();
		end
		exp_l = mix_model(i_audio_l, i_audio_r, i_audio_signed, i_audio_mix, cur_att);
		@(negedge clk_sys);
		i_audio_l = i_audio_l ^ 16'h5a5a;
		@(negedge clk_sys);
		i_audio_l = i_audio_l ^ 16'h5a5a;
		repeat (16) begin
			@(posedge clk_sys);
			check_val("audio_l after glitch", exp_l, o_audio_l, 0);
		end
		end_test();

		start_test("attenuation");
		for (int i = 0; i < 4; i++) begin
			cur_att = {1'b0, 4'($urandom)};
			host_frame(`CMD_VOLUME, {11'b0, cur_att});
			set_audio(16'($urandom), 16'($urandom), 1'b1, 2'($urandom));
			check_mix();
		end
		cur_att = {1'b1, 4'h3};
		host_frame(`CMD_VOLUME, {11'b0, cur_att});
		set_audio(16'($urandom), 16'($urandom), 1'b1, 2'd0);
		check_val("muted audio_l", 0, o_audio_l, 0);
		check_val("muted audio_r", 0, o_audio_r, 0);
		cur_att = '0;
		host_frame(`CMD_VOLUME, 16'h0000);
		set_audio(16'h7fff, 16'h7fff, 1'b1, 2'd3);
		check_mix();
		set_audio(16'h8000, 16'h8000, 1'b1, 2'd3);
		check_mix();
		end_test();

		start_test("dac_density");
		set_audio(16'($urandom), 16'($urandom), 1'b1, 2'd0);
		exp_l = mix_model(i_audio_l, i_audio_r, 1'b1, 2'd0, cur_att);
		exp_r = mix_model(i_audio_r, i_audio_l, 1'b1, 2'd0, cur_att);
		ones_l = 0;
		ones_r = 0;
		repeat (65536) begin
			@(posedge clk_sys);
			ones_l += int'(o_dac_l);
			ones_r += int'(o_dac_r);
		end
		// Offset binary of the settled output sample
		check_val("dac_l ones", (exp_l & 32'hffff) ^ 32'h8000, ones_l, 1);
		check_val("dac_r ones", (exp_r & 32'hffff) ^ 32'h8000, ones_r, 1);
		end_test();

		start_test("sync_polarity");
		run_sync(1'b0, 0, 200, 1'b1);
		run_sync(1'b1, 200, 128, 1'b0);
		run_sync(1'b1, 328, 192, 1'b1);
		end_test();

		$display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/sys_pkg.sv
src/hps_cmd_regs.sv
src/audio_mix.sv
src/audio_dac.sv
src/sync_polarity.sv
src/sys_top.sv
tests/tb_sys_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_sys_top \
	-f verilog.f -o tb_sys_top &&
./obj_dir/tb_sys_top | tee /dev/stderr | grep "Regression passed" > /dev/null &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }
